// File: Makefile
# Verilator flow for the mini-golf gameplay core
VERILATOR ?= verilator
TOP       ?= golf_gameplay_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fail when the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/golf_gameplay_assertions.sv
`timescale 1ns/1ps

module golf_gameplay_assertions (
    input logic                        clk_in,
    input logic                        rst_n,
    input logic                        new_game,
    input logic                        advance,
    input course_map_pkg::wall_e       wall_snap,
    input logic [15:0]                 ball_speed,
    input logic [7:0]                  score,
    input golf_rules_pkg::game_state_e state
);

    int fail_cnt = 0;                   // Count of failed properties

    a_advance_pulse : assert property (@(posedge clk_in) disable iff (!rst_n)
        advance |=> !advance)
        else begin
            $error("advance stayed high for more than one cycle");
            fail_cnt++;
        end

    a_snap_or_move : assert property (@(posedge clk_in) disable iff (!rst_n)
        !(advance && wall_snap != course_map_pkg::W_NONE))
        else begin
            $error("wall snap and advance in the same cycle");
            fail_cnt++;
        end

    a_speed_cap : assert property (@(posedge clk_in) disable iff (!rst_n)
        ball_speed <= golf_rules_pkg::MAX_INIT_SPEED)
        else begin
            $error("ball speed above the top of the charge ramp");
            fail_cnt++;
        end

    // Score moves only when a stroke completes or on restart
    a_score_step : assert property (@(posedge clk_in) disable iff (!rst_n)
        score != $past(score) |-> $past(new_game)
            || ($past(state) == golf_rules_pkg::ON_HIT && state == golf_rules_pkg::MOVING))
        else begin
            $error("score changed outside the end of ON_HIT");
            fail_cnt++;
        end

endmodule

bind golf_gameplay golf_gameplay_assertions asrt0 (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .new_game   (new_game),
    .advance    (advance),
    .wall_snap  (wall_snap),
    .ball_speed (ball_speed),
    .score      (score),
    .state      (state)
);

// File: bench/golf_gameplay_tb.sv
`timescale 1ns/1ps

module golf_gameplay_tb;

    logic clk_in = 1'b0;
    logic rst_n;
    logic new_game;
    logic charging_hit;
    logic pan_left;
    logic pan_right;
    logic new_frame;
    logic map_wr_en;
    logic [7:0] map_wr_addr;
    course_map_pkg::terrain_e map_wr_data;
    logic [15:0] ball_x;
    logic [15:0] ball_y;
    logic [15:0] ball_speed;
    logic [2:0] direction;
    logic [2:0] aim;
    logic [7:0] score;
    golf_rules_pkg::game_state_e state;

    course_map_pkg::terrain_e tb_map [256];   // Reference copy of the course
    int seed;
    int m_x;                                  // Model of ball and stroke
    int m_y;
    int m_speed;
    int m_dir;
    int m_aim;
    int m_score;
    golf_rules_pkg::game_state_e m_state;

    string shot_name [4] = '{"bounce_x", "hole_in", "bounce_y", "free_roll"};
    int shot_pan [4]     = '{4, 4, -2, 2};    // Negative pans right
    int shot_hold [4]    = '{5, 5, 5, 59};    // 59 lands on the falling side of the ramp
    int shot_frames [4]  = '{60, 60, 60, 100};
    int shot_score [4]   = '{1, 2, 1, 2};
    golf_rules_pkg::game_state_e shot_state [4] = '{golf_rules_pkg::RESTING,
        golf_rules_pkg::IN_HOLE, golf_rules_pkg::RESTING, golf_rules_pkg::RESTING};

    golf_gameplay dut0 (.*);

    always #2 clk_in = ~clk_in;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    function automatic int dir_cos(int d);
        case (d)
            0: return 256;
            1, 7: return 181;                 // 45 degree components
            3, 5: return -181;
            4: return -256;
            default: return 0;
        endcase
    endfunction

    function automatic int dir_sin(int d);
        return dir_cos((d + 6) & 7);          // Quarter turn back
    endfunction

    function automatic course_map_pkg::terrain_e terrain_at(int px, int py);
        if (px < 0 || py < 0 || (px >> 8) >= 16 || (py >> 8) >= 16) begin
            return course_map_pkg::WALL;      // Off the course
        end
        return tb_map[(py >> 8) * 16 + (px >> 8)];
    endfunction

    function automatic course_map_pkg::wall_e wall_seen();
        if (terrain_at(m_x + 'h70, m_y) == course_map_pkg::WALL) return course_map_pkg::W_XPLUS;
        if (terrain_at(m_x, m_y + 'h70) == course_map_pkg::WALL) return course_map_pkg::W_YPLUS;
        if (terrain_at(m_x - 'h70, m_y) == course_map_pkg::WALL) return course_map_pkg::W_XMINUS;
        if (terrain_at(m_x, m_y - 'h70) == course_map_pkg::WALL) return course_map_pkg::W_YMINUS;
        return course_map_pkg::W_NONE;
    endfunction

    function automatic int ramp_after(int hold);
        int spd;
        bit up;
        spd = 0;
        up = 1'b1;
        for (int s = 0; s < (hold - 1) / 2; s++) begin  // First held cycle enters CHARGING
            spd = up ? spd + 32 : spd - 32;
            if (spd == 512) up = 1'b0;
            if (spd == 0) up = 1'b1;
        end
        return spd;
    endfunction

    task automatic model_frame();
        course_map_pkg::terrain_e under;
        course_map_pkg::wall_e w;
        int mc;
        int ms;
        int decel;
        under = terrain_at(m_x, m_y);
        w = wall_seen();
        mc = dir_cos(m_dir);
        ms = dir_sin(m_dir);
        if (under == course_map_pkg::HOLE && m_speed < 128) begin
            m_state = golf_rules_pkg::IN_HOLE;
        end else if (m_speed == 0) begin
            m_state = golf_rules_pkg::RESTING;
        end else if (w != course_map_pkg::W_NONE) begin
            if (w == course_map_pkg::W_XPLUS || w == course_map_pkg::W_XMINUS) begin
                m_dir = (4 - m_dir) & 7;
            end else begin
                m_dir = (8 - m_dir) & 7;
            end
            case (w)
                course_map_pkg::W_XPLUS:  m_x = m_x & 'hFF00;
                course_map_pkg::W_YPLUS:  m_y = m_y & 'hFF00;
                course_map_pkg::W_XMINUS: m_x = (((m_x >> 8) + 1) << 8) & 'hFFFF;
                default:                  m_y = (((m_y >> 8) + 1) << 8) & 'hFFFF;
            endcase
        end else begin
            m_x = (mc < 0 ? m_x - ((m_speed * -mc) >> 8) : m_x + ((m_speed * mc) >> 8)) & 'hFFFF;
            m_y = (ms < 0 ? m_y - ((m_speed * -ms) >> 8) : m_y + ((m_speed * ms) >> 8)) & 'hFFFF;
            decel = (under == course_map_pkg::SAND) ? 10 : (under == course_map_pkg::GRASS) ? 2 : 0;
            m_speed = (m_speed > decel) ? m_speed - decel : 0;
        end
    endtask

    task automatic check_ball(string tag);
        check_value({tag, " ball_x"}, m_x, int'(ball_x));
        check_value({tag, " ball_y"}, m_y, int'(ball_y));
        check_value({tag, " speed"}, m_speed, int'(ball_speed));
        check_value({tag, " direction"}, m_dir, int'(direction));
        check_value({tag, " state"}, int'(m_state), int'(state));
        check_value({tag, " score"}, m_score, int'(score));
    endtask

    task automatic model_reset();
        m_x = 'h0280;                         // Centre of tile 2,2
        m_y = 'h0280;
        m_speed = 0;
        m_dir = 0;
        m_aim = 0;
        m_score = 0;
        m_state = golf_rules_pkg::RESTING;
    endtask

    task automatic play_shot(int i);
        int n;
        pan_left = shot_pan[i] > 0;
        pan_right = shot_pan[i] < 0;
        repeat (4 * (shot_pan[i] < 0 ? -shot_pan[i] : shot_pan[i])) @(negedge clk_in);
        pan_left = 1'b0;
        pan_right = 1'b0;
        @(negedge clk_in);
        m_aim = (m_aim + shot_pan[i]) & 7;
        check_value({shot_name[i], " aim"}, m_aim, int'(aim));
        charging_hit = 1'b1;
        repeat (shot_hold[i]) @(negedge clk_in);
        charging_hit = 1'b0;
        n = 0;
        while (state != golf_rules_pkg::MOVING) begin
            if (n == 20) fail_run({shot_name[i], " never reached MOVING after release"});
            @(negedge clk_in);
            n++;
        end
        m_speed = ramp_after(shot_hold[i]);
        m_dir = m_aim;
        m_score++;
        m_state = golf_rules_pkg::MOVING;
        check_ball({shot_name[i], " launch"});
        n = 0;
        while (state == golf_rules_pkg::MOVING) begin
            if (n == shot_frames[i]) fail_run({shot_name[i], " ball kept moving too long"});
            repeat (4) @(negedge clk_in);     // Probes settle between frames
            new_frame = 1'b1;
            @(negedge clk_in);
            new_frame = 1'b0;
            model_frame();
            check_ball($sformatf("%s frame %0d", shot_name[i], n));
            n++;
        end
        check_value({shot_name[i], " end state"}, int'(shot_state[i]), int'(state));
        check_value({shot_name[i], " end score"}, shot_score[i], int'(score));
        if (state == golf_rules_pkg::IN_HOLE) begin
            pan_left = 1'b1;                  // Aim still turns while holed out
            repeat (4) @(negedge clk_in);
            pan_left = 1'b0;
            m_aim = (m_aim + 1) & 7;
            check_value({shot_name[i], " pan in hole"}, m_aim, int'(aim));
            new_game = 1'b1;                  // Restart after holing out
            @(negedge clk_in);
            new_game = 1'b0;
            model_reset();
            check_ball({shot_name[i], " new_game"});
            check_value({shot_name[i], " new_game aim"}, 0, int'(aim));
        end
    endtask

    initial begin
        #200000;
        fail_run("simulation ran past its time limit");
    end

    initial begin
        seed = 47;
        rst_n = 1'b0;
        new_game = 1'b0;
        charging_hit = 1'b0;
        pan_left = 1'b0;
        pan_right = 1'b0;
        new_frame = 1'b0;
        map_wr_en = 1'b0;
        map_wr_addr = '0;
        map_wr_data = course_map_pkg::GRASS;
        for (int a = 0; a < 256; a++) begin   // Wall border with grass inside
            tb_map[a] = (a < 16 || a >= 240 || a % 16 == 0 || a % 16 == 15)
                      ? course_map_pkg::WALL : course_map_pkg::GRASS;
        end
        for (int k = 0; k < 12; k++) begin    // Sand in rows 4 to 13, off the hole row
            tb_map[(4 + $unsigned($random(seed)) % 10) * 16
                   + 1 + $unsigned($random(seed)) % 14] = course_map_pkg::SAND;
        end
        tb_map[4 * 16 + 6] = course_map_pkg::SAND;  // Sits on the free roll path
        tb_map[2 * 16 + 9] = course_map_pkg::HOLE;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        rst_n = 1'b1;
        model_reset();
        check_ball("after_reset");
        for (int a = 0; a < 256; a++) begin
            map_wr_en = 1'b1;
            map_wr_addr = 8'(a);
            map_wr_data = tb_map[a];
            @(negedge clk_in);
        end
        map_wr_en = 1'b0;
        repeat (2) @(negedge clk_in);
        for (int i = 0; i < 4; i++) begin
            play_shot(i);
        end
        if (dut0.asrt0.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: hw/ball_motion.sv
`timescale 1ns/1ps

module ball_motion (
    input  logic                             clk_in,
    input  logic                             rst_n,
    input  logic                             new_game,
    input  logic                             advance,
    input  course_map_pkg::wall_e            wall_snap,
    input  logic [golf_rules_pkg::POS_W-1:0] ball_speed,
    input  logic [golf_rules_pkg::AIM_W-1:0] direction,
    output logic [golf_rules_pkg::POS_W-1:0] ball_x,
    output logic [golf_rules_pkg::POS_W-1:0] ball_y
);

    logic [golf_rules_pkg::DIR_W-1:0] cos_e;
    logic [golf_rules_pkg::DIR_W-1:0] sin_e;
    logic [golf_rules_pkg::POS_W+golf_rules_pkg::FRAC_W:0] prod_x;  // Speed times magnitude
    logic [golf_rules_pkg::POS_W+golf_rules_pkg::FRAC_W:0] prod_y;
    logic [golf_rules_pkg::POS_W-1:0] step_x;
    logic [golf_rules_pkg::POS_W-1:0] step_y;
    logic [golf_rules_pkg::POS_W-1:0] next_x;
    logic [golf_rules_pkg::POS_W-1:0] next_y;

    assign cos_e = golf_rules_pkg::DIR_COS[direction];
    assign sin_e = golf_rules_pkg::DIR_SIN[direction];

    assign prod_x = ball_speed * cos_e[golf_rules_pkg::FRAC_W:0];
    assign prod_y = ball_speed * sin_e[golf_rules_pkg::FRAC_W:0];
    assign step_x = prod_x[golf_rules_pkg::POS_W+golf_rules_pkg::FRAC_W-1:golf_rules_pkg::FRAC_W];
    assign step_y = prod_y[golf_rules_pkg::POS_W+golf_rules_pkg::FRAC_W-1:golf_rules_pkg::FRAC_W];

    assign next_x = cos_e[golf_rules_pkg::DIR_W-1] ? ball_x - step_x : ball_x + step_x;
    assign next_y = sin_e[golf_rules_pkg::DIR_W-1] ? ball_y - step_y : ball_y + step_y;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            ball_x <= golf_rules_pkg::START_X;
            ball_y <= golf_rules_pkg::START_Y;
        end else if (new_game) begin
            ball_x <= golf_rules_pkg::START_X;
            ball_y <= golf_rules_pkg::START_Y;
        end else if (advance) begin             // Uses speed before this frame's drag
            ball_x <= next_x;
            ball_y <= next_y;
        end else begin
            case (wall_snap)
                course_map_pkg::W_XPLUS: begin  // Back to the left edge of the tile
                    ball_x <= {ball_x[15:8], 8'h00};
                end
                course_map_pkg::W_YPLUS: begin
                    ball_y <= {ball_y[15:8], 8'h00};
                end
                course_map_pkg::W_XMINUS: begin // Up to the next tile boundary
                    ball_x <= {ball_x[15:8] + 8'd1, 8'h00};
                end
                course_map_pkg::W_YMINUS: begin
                    ball_y <= {ball_y[15:8] + 8'd1, 8'h00};
                end
                default: ;                      // No frame or no contact
            endcase
        end
    end

endmodule

// File: hw/contact_resolver.sv
`timescale 1ns/1ps

module contact_resolver (
    input  course_map_pkg::terrain_e probe_terrain [course_map_pkg::NUM_PROBES],
    output course_map_pkg::terrain_e under_terrain,
    output course_map_pkg::wall_e    wall
);

    logic hit_xplus;
    logic hit_yplus;
    logic hit_xminus;
    logic hit_yminus;

    // An edge blocks only when its probe sees a wall
    assign hit_xplus  = probe_terrain[course_map_pkg::P_XPLUS]  == course_map_pkg::WALL;
    assign hit_yplus  = probe_terrain[course_map_pkg::P_YPLUS]  == course_map_pkg::WALL;
    assign hit_xminus = probe_terrain[course_map_pkg::P_XMINUS] == course_map_pkg::WALL;
    assign hit_yminus = probe_terrain[course_map_pkg::P_YMINUS] == course_map_pkg::WALL;

    assign under_terrain = probe_terrain[course_map_pkg::P_CENTER];  // Drag and hole test

    always_comb begin
        if (hit_xplus) begin                    // Fixed order x+ y+ x- y-
            wall = course_map_pkg::W_XPLUS;
        end else if (hit_yplus) begin
            wall = course_map_pkg::W_YPLUS;
        end else if (hit_xminus) begin
            wall = course_map_pkg::W_XMINUS;
        end else if (hit_yminus) begin
            wall = course_map_pkg::W_YMINUS;
        end else begin
            wall = course_map_pkg::W_NONE;
        end
    end

endmodule

// File: hw/course_map_pkg.sv
package course_map_pkg;

    typedef enum logic [1:0] {
        HOLE  = 2'd0,
        WALL  = 2'd1,   // Flat wall and also anything off the map
        GRASS = 2'd2,
        SAND  = 2'd3    // Heavier drag than grass
    } terrain_e;

    localparam int MAP_SIDE = 16;  // Tiles per side
    localparam int MAP_AW   = 8;   // Address is row times MAP_SIDE plus column

    typedef enum logic [2:0] {
        P_CENTER,
        P_XPLUS,
        P_XMINUS,
        P_YPLUS,
        P_YMINUS
    } probe_e;

    typedef enum logic [2:0] {
        W_NONE,
        W_XPLUS,    // Highest priority
        W_YPLUS,
        W_XMINUS,
        W_YMINUS
    } wall_e;

    localparam logic [15:0] EDGE_OFS   = 16'h0070;  // Ball radius in 8.8
    localparam int          NUM_PROBES = 5;

endpackage

// File: hw/golf_gameplay.sv
`timescale 1ns/1ps

module golf_gameplay (
    input  logic                              clk_in,
    input  logic                              rst_n,
    input  logic                              new_game,
    input  logic                              charging_hit,
    input  logic                              pan_left,
    input  logic                              pan_right,
    input  logic                              new_frame,
    input  logic                              map_wr_en,
    input  logic [course_map_pkg::MAP_AW-1:0] map_wr_addr,
    input  course_map_pkg::terrain_e          map_wr_data,
    output logic [golf_rules_pkg::POS_W-1:0]  ball_x,
    output logic [golf_rules_pkg::POS_W-1:0]  ball_y,
    output logic [golf_rules_pkg::POS_W-1:0]  ball_speed,
    output logic [golf_rules_pkg::AIM_W-1:0]  direction,
    output logic [golf_rules_pkg::AIM_W-1:0]  aim,
    output logic [7:0]                        score,
    output golf_rules_pkg::game_state_e       state
);

    logic                     advance;          // One pulse per rolling frame
    course_map_pkg::wall_e    wall;
    course_map_pkg::wall_e    wall_snap;        // Wall qualified by a frame
    course_map_pkg::terrain_e under_terrain;
    course_map_pkg::terrain_e probe_terrain [course_map_pkg::NUM_PROBES];

    ball_motion u_motion (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .new_game   (new_game),
        .advance    (advance),
        .wall_snap  (wall_snap),
        .ball_speed (ball_speed),
        .direction  (direction),
        .ball_x     (ball_x),
        .ball_y     (ball_y)
    );

    // Centre probe first then the four edges in probe_e order
    for (genvar i = 0; i < course_map_pkg::NUM_PROBES; i++) begin : g_probe
        terrain_probe #(
            .PROBE (course_map_pkg::probe_e'(i))
        ) u_probe (
            .clk_in        (clk_in),
            .rst_n         (rst_n),
            .map_wr_en     (map_wr_en),
            .map_wr_addr   (map_wr_addr),
            .map_wr_data   (map_wr_data),
            .ball_x        (ball_x),
            .ball_y        (ball_y),
            .probe_terrain (probe_terrain[i])
        );
    end

    contact_resolver u_resolver (
        .probe_terrain (probe_terrain),
        .under_terrain (under_terrain),
        .wall          (wall)
    );

    stroke_fsm u_fsm (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .new_game      (new_game),
        .charging_hit  (charging_hit),
        .pan_left      (pan_left),
        .pan_right     (pan_right),
        .new_frame     (new_frame),
        .under_terrain (under_terrain),
        .wall          (wall),
        .advance       (advance),
        .wall_snap     (wall_snap),
        .ball_speed    (ball_speed),
        .direction     (direction),
        .aim           (aim),
        .score         (score),
        .state         (state)
    );

endmodule

// File: hw/golf_rules_pkg.sv
package golf_rules_pkg;

    typedef enum logic [2:0] {
        RESTING,   // Ball still and waiting for a charge
        CHARGING,  // Speed bar running while charge is held
        ON_HIT,    // Two-cycle strike
        MOVING,    // Rolling and stepped once per frame
        IN_HOLE    // Holed out until restart
    } game_state_e;

    localparam int POS_W  = 16;          // 8.8 fixed point position and speed
    localparam int FRAC_W = 8;           // Fraction bits
    localparam int AIM_W  = 3;           // Eight 45 degree steps
    localparam int DIR_W  = FRAC_W + 2;  // Sign bit over a 9-bit magnitude

    localparam int PAN_THRESH    = 4;    // Held cycles per aim step
    localparam int CHARGE_THRESH = 2;    // Held cycles per speed step

    localparam logic [POS_W-1:0] SPEED_STEP     = 16'd32;
    localparam logic [POS_W-1:0] MAX_INIT_SPEED = 16'd512;  // Two tiles per frame
    localparam logic [POS_W-1:0] GRASS_DECEL    = 16'd2;
    localparam logic [POS_W-1:0] SAND_DECEL     = 16'd10;
    localparam logic [POS_W-1:0] SCORE_SPEED    = 16'd128;  // Half a tile per frame

    localparam logic [POS_W-1:0] START_X = 16'h0280;       // Centre of tile 2
    localparam logic [POS_W-1:0] START_Y = 16'h0280;

    // Top bit is the sign
    // Magnitude 256 is 1.0 and 181 is about 0.707
    localparam logic [7:0][DIR_W-1:0] DIR_COS = {
        10'h0B5, 10'h000, 10'h2B5, 10'h300,  // Entries 7 down to 4
        10'h2B5, 10'h000, 10'h0B5, 10'h100   // Entries 3 down to 0
    };

    localparam logic [7:0][DIR_W-1:0] DIR_SIN = {
        10'h2B5, 10'h300, 10'h2B5, 10'h000,  // Entries 7 down to 4
        10'h0B5, 10'h100, 10'h0B5, 10'h000   // Entries 3 down to 0
    };

endpackage

// File: hw/stroke_fsm.sv
`timescale 1ns/1ps

module stroke_fsm (
    input  logic                             clk_in,
    input  logic                             rst_n,
    input  logic                             new_game,
    input  logic                             charging_hit,
    input  logic                             pan_left,
    input  logic                             pan_right,
    input  logic                             new_frame,
    input  course_map_pkg::terrain_e         under_terrain,
    input  course_map_pkg::wall_e            wall,
    output logic                             advance,
    output course_map_pkg::wall_e            wall_snap,
    output logic [golf_rules_pkg::POS_W-1:0] ball_speed,
    output logic [golf_rules_pkg::AIM_W-1:0] direction,
    output logic [golf_rules_pkg::AIM_W-1:0] aim,
    output logic [7:0]                       score,
    output golf_rules_pkg::game_state_e      state
);

    logic [$clog2(golf_rules_pkg::PAN_THRESH)-1:0]    pan_l_cnt;
    logic [$clog2(golf_rules_pkg::PAN_THRESH)-1:0]    pan_r_cnt;
    logic [$clog2(golf_rules_pkg::CHARGE_THRESH)-1:0] charge_cnt;
    logic pan_l_step;
    logic pan_r_step;
    logic charge_step;
    logic ramp_up;                              // Speed bar direction
    logic hit_cnt;                              // Second cycle of ON_HIT
    logic frame_go;
    logic hole_hit;
    logic rest_hit;
    logic [golf_rules_pkg::POS_W-1:0] ramp_speed;
    logic [golf_rules_pkg::POS_W-1:0] decel;
    logic [golf_rules_pkg::POS_W-1:0] speed_decay;
    logic [golf_rules_pkg::AIM_W-1:0] reflect_dir;

    assign pan_l_step  = pan_left && int'(pan_l_cnt) == golf_rules_pkg::PAN_THRESH - 1;
    assign pan_r_step  = pan_right && int'(pan_r_cnt) == golf_rules_pkg::PAN_THRESH - 1;
    assign charge_step = int'(charge_cnt) == golf_rules_pkg::CHARGE_THRESH - 1;
    assign ramp_speed  = ramp_up ? ball_speed + golf_rules_pkg::SPEED_STEP
                                 : ball_speed - golf_rules_pkg::SPEED_STEP;

    // Frame decision in priority order hole, rest, bounce, roll
    assign frame_go  = state == golf_rules_pkg::MOVING && new_frame;
    assign hole_hit  = under_terrain == course_map_pkg::HOLE
                    && ball_speed < golf_rules_pkg::SCORE_SPEED;
    assign rest_hit  = ball_speed == '0;
    assign advance   = frame_go && !hole_hit && !rest_hit && wall == course_map_pkg::W_NONE;
    assign wall_snap = (frame_go && !hole_hit && !rest_hit) ? wall : course_map_pkg::W_NONE;

    always_comb begin
        case (under_terrain)
            course_map_pkg::GRASS: decel = golf_rules_pkg::GRASS_DECEL;
            course_map_pkg::SAND:  decel = golf_rules_pkg::SAND_DECEL;
            default:               decel = '0;  // Hole and wall add no drag
        endcase
        speed_decay = (ball_speed > decel) ? ball_speed - decel : '0;
        if (wall == course_map_pkg::W_XPLUS || wall == course_map_pkg::W_XMINUS) begin
            reflect_dir = 3'd4 - direction;      // Mirror about the y axis
        end else begin
            reflect_dir = 3'd0 - direction;      // Mirror about the x axis
        end
    end

    // Aim runs in every state
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            aim       <= '0;
            pan_l_cnt <= '0;
            pan_r_cnt <= '0;
        end else if (new_game) begin
            aim       <= '0;
            pan_l_cnt <= '0;
            pan_r_cnt <= '0;
        end else begin
            pan_l_cnt <= (pan_left && !pan_l_step) ? pan_l_cnt + 1'b1 : '0;
            pan_r_cnt <= (pan_right && !pan_r_step) ? pan_r_cnt + 1'b1 : '0;
            aim       <= aim + {2'b00, pan_l_step} - {2'b00, pan_r_step};  // Wraps mod 8
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state      <= golf_rules_pkg::RESTING;
            ball_speed <= '0;
            direction  <= '0;
            score      <= '0;
            charge_cnt <= '0;
            ramp_up    <= 1'b1;
            hit_cnt    <= 1'b0;
        end else if (new_game) begin
            state      <= golf_rules_pkg::RESTING;
            ball_speed <= '0;
            direction  <= '0;
            score      <= '0;
            charge_cnt <= '0;
            ramp_up    <= 1'b1;
            hit_cnt    <= 1'b0;
        end else begin
            case (state)
                golf_rules_pkg::RESTING: begin
                    charge_cnt <= '0;
                    ramp_up    <= 1'b1;
                    if (charging_hit) begin
                        state <= golf_rules_pkg::CHARGING;
                    end
                end
                golf_rules_pkg::CHARGING: begin
                    if (!charging_hit) begin    // Release strikes
                        state   <= golf_rules_pkg::ON_HIT;
                        hit_cnt <= 1'b0;
                    end else if (charge_step) begin
                        charge_cnt <= '0;
                        ball_speed <= ramp_speed;
                        if (ramp_up && ramp_speed == golf_rules_pkg::MAX_INIT_SPEED) begin
                            ramp_up <= 1'b0;    // Top of the bar
                        end else if (!ramp_up && ramp_speed == '0) begin
                            ramp_up <= 1'b1;    // Bottom of the bar
                        end
                    end else begin
                        charge_cnt <= charge_cnt + 1'b1;
                    end
                end
                golf_rules_pkg::ON_HIT: begin
                    hit_cnt <= 1'b1;
                    if (!hit_cnt) begin
                        direction <= aim;       // Latch the shot direction
                    end else begin
                        score <= score + 8'd1;
                        state <= golf_rules_pkg::MOVING;
                    end
                end
                golf_rules_pkg::MOVING: begin
                    if (frame_go) begin
                        if (hole_hit) begin
                            state <= golf_rules_pkg::IN_HOLE;
                        end else if (rest_hit) begin
                            state <= golf_rules_pkg::RESTING;
                        end else if (wall != course_map_pkg::W_NONE) begin
                            direction <= reflect_dir;  // Position snaps in ball_motion
                        end else begin
                            ball_speed <= speed_decay;
                        end
                    end
                end
                default: ;                      // IN_HOLE waits for new_game
            endcase
        end
    end

endmodule

// File: hw/terrain_probe.sv
`timescale 1ns/1ps

module terrain_probe #(
    parameter course_map_pkg::probe_e PROBE = course_map_pkg::P_CENTER
) (
    input  logic                              clk_in,
    input  logic                              rst_n,
    input  logic                              map_wr_en,
    input  logic [course_map_pkg::MAP_AW-1:0] map_wr_addr,
    input  course_map_pkg::terrain_e          map_wr_data,
    input  logic [golf_rules_pkg::POS_W-1:0]  ball_x,
    input  logic [golf_rules_pkg::POS_W-1:0]  ball_y,
    output course_map_pkg::terrain_e          probe_terrain
);

    course_map_pkg::terrain_e map_mem [course_map_pkg::MAP_SIDE * course_map_pkg::MAP_SIDE];

    logic [golf_rules_pkg::POS_W:0] edge_ofs;   // Spare top bit flags wrap
    logic [golf_rules_pkg::POS_W:0] probe_x;
    logic [golf_rules_pkg::POS_W:0] probe_y;
    logic [golf_rules_pkg::FRAC_W:0] tile_x;    // Integer part plus wrap bit
    logic [golf_rules_pkg::FRAC_W:0] tile_y;
    logic off_map;
    logic [course_map_pkg::MAP_AW-1:0] rd_addr;

    assign edge_ofs = {1'b0, course_map_pkg::EDGE_OFS};

    always_comb begin
        probe_x = {1'b0, ball_x};               // Centre unless an edge probe
        probe_y = {1'b0, ball_y};
        case (PROBE)
            course_map_pkg::P_XPLUS:  probe_x = {1'b0, ball_x} + edge_ofs;
            course_map_pkg::P_XMINUS: probe_x = {1'b0, ball_x} - edge_ofs;
            course_map_pkg::P_YPLUS:  probe_y = {1'b0, ball_y} + edge_ofs;
            course_map_pkg::P_YMINUS: probe_y = {1'b0, ball_y} - edge_ofs;
            default: ;
        endcase
    end

    assign tile_x  = probe_x[golf_rules_pkg::POS_W:golf_rules_pkg::FRAC_W];
    assign tile_y  = probe_y[golf_rules_pkg::POS_W:golf_rules_pkg::FRAC_W];
    assign off_map = int'(tile_x) >= course_map_pkg::MAP_SIDE
                  || int'(tile_y) >= course_map_pkg::MAP_SIDE;  // Underflow lands here too
    assign rd_addr = course_map_pkg::MAP_AW'(int'(tile_y) * course_map_pkg::MAP_SIDE
                                             + int'(tile_x));

    always_ff @(posedge clk_in) begin
        if (map_wr_en) begin
            map_mem[map_wr_addr] <= map_wr_data;  // Same map goes to every copy
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            probe_terrain <= course_map_pkg::WALL;
        end else begin
            probe_terrain <= off_map ? course_map_pkg::WALL : map_mem[rd_addr];
        end
    end

endmodule

// File: src.f
hw/golf_rules_pkg.sv
hw/course_map_pkg.sv
hw/terrain_probe.sv
hw/contact_resolver.sv
hw/ball_motion.sv
hw/stroke_fsm.sv
hw/golf_gameplay.sv
bench/golf_gameplay_assertions.sv
bench/golf_gameplay_tb.sv
